/* hdl/axi_xbar.sv */
module axi_xbar (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  soc_pkg::axi_req_t m_req_i,
  output soc_pkg::axi_rsp_t m_rsp_o,
  input  soc_pkg::axi_rsp_t s_rsp_i [soc_pkg::NUM_SLAVES],
  output soc_pkg::axi_req_t s_req_o [soc_pkg::NUM_SLAVES]
);

  soc_pkg::slave_sel_e aw_sel;
  soc_pkg::slave_sel_e ar_sel;
  soc_pkg::slave_sel_e wr_sel_q;
  soc_pkg::slave_sel_e rd_sel_q;
  logic                wr_busy_q;
  logic                rd_busy_q;
  logic                wr_accept;
  logic                rd_accept;
  logic                b_done;
  logic                r_done;

  // Upper nibble picks the slave, everything unmapped lands on the error slave
  function automatic soc_pkg::slave_sel_e decode(input soc_pkg::addr_t addr);
    case (addr[soc_pkg::ADDR_W-1 -: 4])
      soc_pkg::SRAM_REGION: return soc_pkg::SEL_SRAM;
      soc_pkg::CONF_REGION: return soc_pkg::SEL_CONF;
      default:              return soc_pkg::SEL_ERR;
    endcase
  endfunction

  assign aw_sel = decode(m_req_i.aw_addr);
  assign ar_sel = decode(m_req_i.ar_addr);

  // ------------------------------
  // Request steering
  // ------------------------------
  always_comb begin
    logic hit_aw;
    logic hit_ar;
    logic own_b;
    logic own_r;
    for (int i = 0; i < soc_pkg::NUM_SLAVES; i++) begin
      hit_aw = ~wr_busy_q & (aw_sel == soc_pkg::slave_sel_e'(i));
      hit_ar = ~rd_busy_q & (ar_sel == soc_pkg::slave_sel_e'(i));
      own_b  = wr_busy_q & (wr_sel_q == soc_pkg::slave_sel_e'(i));
      own_r  = rd_busy_q & (rd_sel_q == soc_pkg::slave_sel_e'(i));
      // Payload goes everywhere, only the handshake bits are gated
      s_req_o[i]          = m_req_i;
      s_req_o[i].aw_valid = m_req_i.aw_valid & hit_aw;
      s_req_o[i].w_valid  = m_req_i.w_valid & hit_aw;
      s_req_o[i].b_ready  = m_req_i.b_ready & own_b;
      s_req_o[i].ar_valid = m_req_i.ar_valid & hit_ar;
      s_req_o[i].r_ready  = m_req_i.r_ready & own_r;
    end
  end

  // ------------------------------
  // Response routing
  // ------------------------------
  always_comb begin
    m_rsp_o.aw_ready = ~wr_busy_q & s_rsp_i[aw_sel].aw_ready;
    m_rsp_o.w_ready  = ~wr_busy_q & s_rsp_i[aw_sel].w_ready;
    m_rsp_o.ar_ready = ~rd_busy_q & s_rsp_i[ar_sel].ar_ready;
    // Responses come back from the slave that took the request
    m_rsp_o.b_valid  = wr_busy_q & s_rsp_i[wr_sel_q].b_valid;
    m_rsp_o.b_resp   = s_rsp_i[wr_sel_q].b_resp;
    m_rsp_o.r_valid  = rd_busy_q & s_rsp_i[rd_sel_q].r_valid;
    m_rsp_o.r_data   = s_rsp_i[rd_sel_q].r_data;
    m_rsp_o.r_resp   = s_rsp_i[rd_sel_q].r_resp;
  end

  assign wr_accept = m_req_i.aw_valid & m_req_i.w_valid & m_rsp_o.aw_ready & m_rsp_o.w_ready;
  assign rd_accept = m_req_i.ar_valid & m_rsp_o.ar_ready;
  assign b_done    = m_rsp_o.b_valid & m_req_i.b_ready;
  assign r_done    = m_rsp_o.r_valid & m_req_i.r_ready;

  // One outstanding transfer per direction
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_busy_q <= 1'b0;
      wr_sel_q  <= soc_pkg::SEL_ERR;
    end else if (wr_accept) begin
      wr_busy_q <= 1'b1;
      wr_sel_q  <= aw_sel;
    end else if (b_done) begin
      wr_busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_busy_q <= 1'b0;
      rd_sel_q  <= soc_pkg::SEL_ERR;
    end else if (rd_accept) begin
      rd_busy_q <= 1'b1;
      rd_sel_q  <= ar_sel;
    end else if (r_done) begin
      rd_busy_q <= 1'b0;
    end
  end

  // A slave only answers in a direction that it owns
  for (genvar i = 0; i < soc_pkg::NUM_SLAVES; i++) begin : g_own_chk
    a_b_owned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      s_rsp_i[i].b_valid |-> wr_busy_q && (wr_sel_q == soc_pkg::slave_sel_e'(i)));
    a_r_owned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      s_rsp_i[i].r_valid |-> rd_busy_q && (rd_sel_q == soc_pkg::slave_sel_e'(i)));
  end

endmodule

/* hdl/confreg.sv */
module confreg (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  soc_pkg::axi_req_t req_i,
  input  logic [31:0]       dip_sw_i,
  input  logic [3:0]        touch_btn_i,
  output soc_pkg::axi_rsp_t rsp_o,
  output logic [15:0]       leds_o,
  output soc_pkg::seg7_t    dpy0_o,
  output soc_pkg::seg7_t    dpy1_o
);

  soc_pkg::data_t led_q;
  soc_pkg::data_t seg_q;
  soc_pkg::data_t rd_mux;
  soc_pkg::data_t r_data_q;
  logic           b_valid_q;
  logic           r_valid_q;
  logic           wr_accept;
  logic           rd_accept;
  logic [7:0]     wr_ofs;
  logic [7:0]     rd_ofs;

  // Hex digit to segment pattern with the dp dark
  function automatic soc_pkg::seg7_t hex_to_seg(input logic [3:0] digit);
    case (digit)
      4'h0: return 8'h3F;
      4'h1: return 8'h06;
      4'h2: return 8'h5B;
      4'h3: return 8'h4F;
      4'h4: return 8'h66;
      4'h5: return 8'h6D;
      4'h6: return 8'h7D;
      4'h7: return 8'h07;
      4'h8: return 8'h7F;
      4'h9: return 8'h6F;
      4'hA: return 8'h77;
      4'hB: return 8'h7C;
      4'hC: return 8'h39;
      4'hD: return 8'h5E;
      4'hE: return 8'h79;
      default: return 8'h71;
    endcase
  endfunction

  assign wr_ofs    = req_i.aw_addr[7:0];
  assign rd_ofs    = req_i.ar_addr[7:0];
  assign wr_accept = req_i.aw_valid & req_i.w_valid & ~b_valid_q;
  assign rd_accept = req_i.ar_valid & ~r_valid_q;

  // ------------------------------
  // Register writes
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      led_q <= '0;
      seg_q <= '0;
    end else if (wr_accept) begin
      if (wr_ofs == soc_pkg::CR_LED_OFS) begin
        led_q <= soc_pkg::strb_merge(led_q, req_i.w_data, req_i.w_strb);
      end
      if (wr_ofs == soc_pkg::CR_SEG_OFS) begin
        seg_q <= soc_pkg::strb_merge(seg_q, req_i.w_data, req_i.w_strb);
      end
    end
  end

  // Unused offsets read as zero
  always_comb begin
    case (rd_ofs)
      soc_pkg::CR_LED_OFS: rd_mux = led_q;
      soc_pkg::CR_SEG_OFS: rd_mux = seg_q;
      soc_pkg::CR_SW_OFS:  rd_mux = dip_sw_i;
      soc_pkg::CR_BTN_OFS: rd_mux = {28'd0, touch_btn_i};
      default:             rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rd_accept) begin
      r_data_q <= rd_mux;
    end
  end

  // ------------------------------
  // Response channels
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      b_valid_q <= wr_accept | (b_valid_q & ~req_i.b_ready);
      r_valid_q <= rd_accept | (r_valid_q & ~req_i.r_ready);
    end
  end

  always_comb begin
    rsp_o.aw_ready = wr_accept;
    rsp_o.w_ready  = wr_accept;
    rsp_o.b_valid  = b_valid_q;
    rsp_o.b_resp   = soc_pkg::OKAY;
    rsp_o.ar_ready = rd_accept;
    rsp_o.r_valid  = r_valid_q;
    rsp_o.r_data   = r_data_q;
    rsp_o.r_resp   = soc_pkg::OKAY;
  end

  assign leds_o = led_q[15:0];
  assign dpy0_o = hex_to_seg(seg_q[3:0]);
  assign dpy1_o = hex_to_seg(seg_q[7:4]);

  // No new read arrives while read data is still pending
  a_no_rd_overlap: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_o.r_valid |-> !req_i.ar_valid);

endmodule

/* hdl/error_slave.sv */
module error_slave (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  soc_pkg::axi_req_t req_i,
  output soc_pkg::axi_rsp_t rsp_o
);

  logic b_valid_q;
  logic r_valid_q;
  logic wr_accept;
  logic rd_accept;

  // Takes anything so stray accesses cannot stall the bus
  assign wr_accept = req_i.aw_valid & req_i.w_valid & ~b_valid_q;
  assign rd_accept = req_i.ar_valid & ~r_valid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      b_valid_q <= wr_accept | (b_valid_q & ~req_i.b_ready);
      r_valid_q <= rd_accept | (r_valid_q & ~req_i.r_ready);
    end
  end

  always_comb begin
    rsp_o.aw_ready = wr_accept;
    rsp_o.w_ready  = wr_accept;
    rsp_o.b_valid  = b_valid_q;
    rsp_o.b_resp   = soc_pkg::DECERR;
    rsp_o.ar_ready = rd_accept;
    rsp_o.r_valid  = r_valid_q;
    rsp_o.r_data   = '0;
    rsp_o.r_resp   = soc_pkg::DECERR;
  end

endmodule

/* hdl/soc_pkg.sv */
package soc_pkg;

  // ------------------------------
  // Bus widths and base types
  // ------------------------------
  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;
  localparam int STRB_W = DATA_W / 8;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [STRB_W-1:0] strb_t;

  // Response codes as on AXI without EXOKAY
  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    SLVERR = 2'd2,
    DECERR = 2'd3
  } resp_e;

  // Master to slave with one beat per transfer
  typedef struct packed {
    logic  aw_valid;
    addr_t aw_addr;
    logic  w_valid;
    data_t w_data;
    strb_t w_strb;
    logic  b_ready;
    logic  ar_valid;
    addr_t ar_addr;
    logic  r_ready;
  } axi_req_t;

  // Slave to master
  typedef struct packed {
    logic  aw_ready;
    logic  w_ready;
    logic  b_valid;
    resp_e b_resp;
    logic  ar_ready;
    logic  r_valid;
    data_t r_data;
    resp_e r_resp;
  } axi_rsp_t;

  // ------------------------------
  // Address map
  // ------------------------------
  localparam int NUM_SLAVES = 3;

  typedef enum logic [1:0] {
    SEL_SRAM = 2'd0,
    SEL_CONF = 2'd1,
    SEL_ERR  = 2'd2
  } slave_sel_e;

  // Top nibble of the address
  localparam logic [3:0] SRAM_REGION = 4'h8;
  localparam logic [3:0] CONF_REGION = 4'hB;

  // Confreg offsets on address bits 7..0
  localparam logic [7:0] CR_LED_OFS = 8'h00;
  localparam logic [7:0] CR_SEG_OFS = 8'h04;
  localparam logic [7:0] CR_SW_OFS  = 8'h08;
  localparam logic [7:0] CR_BTN_OFS = 8'h0C;

  // Segments a..g on bits 0..6 and the decimal point on bit 7
  typedef logic [7:0] seg7_t;

  // Byte lanes with a set strobe take the new data
  function automatic data_t strb_merge(data_t old_word, data_t new_word, strb_t strb);
    data_t merged;
    merged = old_word;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage

/* hdl/soc_top.sv */
module soc_top (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  soc_pkg::axi_req_t m_req_i,
  output soc_pkg::axi_rsp_t m_rsp_o,
  input  logic [31:0]       dip_sw_i,
  input  logic [3:0]        touch_btn_i,
  output logic [15:0]       leds_o,
  output soc_pkg::seg7_t    dpy0_o,
  output soc_pkg::seg7_t    dpy1_o
);

  // 1K words of on-chip memory
  localparam int SRAM_AW = 10;

  soc_pkg::axi_req_t s_req [soc_pkg::NUM_SLAVES];
  soc_pkg::axi_rsp_t s_rsp [soc_pkg::NUM_SLAVES];

  // ------------------------------
  // Crossbar with one master and three slaves
  // ------------------------------
  axi_xbar u_axi_xbar (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .m_req_i (m_req_i),
    .m_rsp_o (m_rsp_o),
    .s_rsp_i (s_rsp),
    .s_req_o (s_req)
  );

  sram_bridge #(
    .SRAM_AW (SRAM_AW)
  ) u_sram_bridge (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (s_req[soc_pkg::SEL_SRAM]),
    .rsp_o   (s_rsp[soc_pkg::SEL_SRAM])
  );

  confreg u_confreg (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (s_req[soc_pkg::SEL_CONF]),
    .dip_sw_i    (dip_sw_i),
    .touch_btn_i (touch_btn_i),
    .rsp_o       (s_rsp[soc_pkg::SEL_CONF]),
    .leds_o      (leds_o),
    .dpy0_o      (dpy0_o),
    .dpy1_o      (dpy1_o)
  );

  // Unmapped space
  error_slave u_error_slave (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (s_req[soc_pkg::SEL_ERR]),
    .rsp_o   (s_rsp[soc_pkg::SEL_ERR])
  );

endmodule

/* hdl/sram_bridge.sv */
module sram_bridge #(
  parameter int SRAM_AW = 10
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  soc_pkg::axi_req_t req_i,
  output soc_pkg::axi_rsp_t rsp_o
);

  localparam int DEPTH = 2 ** SRAM_AW;

  soc_pkg::data_t     mem [DEPTH];
  soc_pkg::data_t     r_data_q;
  logic               b_valid_q;
  logic               r_valid_q;
  logic               wr_accept;
  logic               rd_accept;
  logic [SRAM_AW-1:0] wr_idx;
  logic [SRAM_AW-1:0] rd_idx;

  // Word index, byte offset bits dropped
  assign wr_idx = req_i.aw_addr[SRAM_AW+1:2];
  assign rd_idx = req_i.ar_addr[SRAM_AW+1:2];

  // Address and data taken together, only while no response is pending
  assign wr_accept = req_i.aw_valid & req_i.w_valid & ~b_valid_q;
  assign rd_accept = req_i.ar_valid & ~r_valid_q;

  // ------------------------------
  // Storage
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (wr_accept) begin
      mem[wr_idx] <= soc_pkg::strb_merge(mem[wr_idx], req_i.w_data, req_i.w_strb);
    end
    if (rd_accept) begin
      r_data_q <= mem[rd_idx];
    end
  end

  // ------------------------------
  // Response channels
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (wr_accept) begin
        b_valid_q <= 1'b1;
      end else if (req_i.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (rd_accept) begin
        r_valid_q <= 1'b1;
      end else if (req_i.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  always_comb begin
    rsp_o.aw_ready = wr_accept;
    rsp_o.w_ready  = wr_accept;
    rsp_o.b_valid  = b_valid_q;
    rsp_o.b_resp   = soc_pkg::OKAY;
    rsp_o.ar_ready = rd_accept;
    rsp_o.r_valid  = r_valid_q;
    rsp_o.r_data   = r_data_q;
    rsp_o.r_resp   = soc_pkg::OKAY;
  end

  // Masters must not issue writes that touch no byte
  a_strb_nonzero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wr_accept |-> req_i.w_strb != '0);

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the SoC testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_soc -o tb_soc
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_soc > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
echo "Simulation PASSED"
exit 0

/* tb.f */
hdl/soc_pkg.sv
hdl/axi_xbar.sv
hdl/sram_bridge.sv
hdl/confreg.sv
hdl/error_slave.sv
hdl/soc_top.sv
testbench/tb_soc.sv

/* testbench/tb_soc.sv */
module tb_soc;

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 8;
  localparam int MAX_STALL  = 5;
  localparam int SRAM_AW    = 10;
  localparam int N_WORDS    = 16;
  localparam int N_MERGE    = 24;
  localparam int N_OVERLAP  = 20;
  // Bus operations over the whole run
  localparam int N_OPS = 2 * N_WORDS + N_MERGE + 16 + 8 + 12 + 2 * N_OVERLAP;

  typedef struct packed {
    logic           is_read;
    soc_pkg::addr_t addr;
    soc_pkg::data_t data;
    soc_pkg::strb_t strb;
    soc_pkg::resp_e resp;
  } txn_t;

  logic              clk;
  logic              rst_n;
  soc_pkg::axi_req_t m_req;
  soc_pkg::axi_rsp_t m_rsp;
  logic [31:0]       dip_sw;
  logic [3:0]        touch_btn;
  logic [15:0]       leds;
  soc_pkg::seg7_t    dpy0;
  soc_pkg::seg7_t    dpy1;

  // Reference model state
  soc_pkg::data_t sram_model [int];
  soc_pkg::data_t led_model;
  soc_pkg::data_t seg_model;
  txn_t           txn_q [$];
  event           txn_ev;

  soc_top soc_top_inst (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .m_req_i     (m_req),
    .m_rsp_o     (m_rsp),
    .dip_sw_i    (dip_sw),
    .touch_btn_i (touch_btn),
    .leds_o      (leds),
    .dpy0_o      (dpy0),
    .dpy1_o      (dpy1)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic soc_pkg::data_t merge_bytes(input soc_pkg::data_t old_w,
                                                 input soc_pkg::data_t new_w,
                                                 input soc_pkg::strb_t strb);
    soc_pkg::data_t res;
    for (int b = 0; b < soc_pkg::STRB_W; b++) begin
      res[8*b +: 8] = strb[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
    end
    return res;
  endfunction

  // Lit segments per hex digit with a..g on bits 0..6
  function automatic soc_pkg::seg7_t seg_pattern(input logic [3:0] digit);
    string          lit;
    soc_pkg::seg7_t pat;
    case (digit)
      4'h0: lit = "abcdef";
      4'h1: lit = "bc";
      4'h2: lit = "abdeg";
      4'h3: lit = "abcdg";
      4'h4: lit = "bcfg";
      4'h5: lit = "acdfg";
      4'h6: lit = "acdefg";
      4'h7: lit = "abc";
      4'h8: lit = "abcdefg";
      4'h9: lit = "abcdfg";
      4'hA: lit = "abcefg";
      4'hB: lit = "cdefg";
      4'hC: lit = "adef";
      4'hD: lit = "bcdeg";
      4'hE: lit = "adefg";
      default: lit = "aefg";
    endcase
    pat = '0;
    for (int i = 0; i < lit.len(); i++) begin
      pat[int'(lit[i] - "a")] = 1'b1;
    end
    return pat;
  endfunction

  function automatic soc_pkg::resp_e ref_resp(input soc_pkg::addr_t addr);
    if (addr[31:28] == soc_pkg::SRAM_REGION || addr[31:28] == soc_pkg::CONF_REGION) begin
      return soc_pkg::OKAY;
    end
    return soc_pkg::DECERR;
  endfunction

  function automatic soc_pkg::data_t ref_read(input soc_pkg::addr_t addr);
    if (addr[31:28] == soc_pkg::SRAM_REGION) begin
      return sram_model[int'(addr[SRAM_AW+1:2])];
    end else if (addr[31:28] == soc_pkg::CONF_REGION) begin
      case (addr[7:0])
        soc_pkg::CR_LED_OFS: return led_model;
        soc_pkg::CR_SEG_OFS: return seg_model;
        soc_pkg::CR_SW_OFS:  return dip_sw;
        soc_pkg::CR_BTN_OFS: return {28'd0, touch_btn};
        default:             return '0;
      endcase
    end
    return '0;
  endfunction

  task automatic apply_write(input txn_t t);
    int idx;
    idx = int'(t.addr[SRAM_AW+1:2]);
    if (t.addr[31:28] == soc_pkg::SRAM_REGION) begin
      sram_model[idx] = merge_bytes(sram_model.exists(idx) ? sram_model[idx] : '0,
                                    t.data, t.strb);
    end else if (t.addr[31:28] == soc_pkg::CONF_REGION) begin
      if (t.addr[7:0] == soc_pkg::CR_LED_OFS) led_model = merge_bytes(led_model, t.data, t.strb);
      if (t.addr[7:0] == soc_pkg::CR_SEG_OFS) seg_model = merge_bytes(seg_model, t.data, t.strb);
    end
  endtask

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic stop_on_error();
    $display("Test failures found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_data(input string name, input soc_pkg::data_t got,
                            input soc_pkg::data_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_resp(input string name, input soc_pkg::resp_e got,
                            input soc_pkg::resp_e exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_leds(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_seg(input string name, input soc_pkg::seg7_t got,
                           input soc_pkg::seg7_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_displays();
    check_leds("leds_o", leds, led_model[15:0]);
    check_seg("dpy0_o", dpy0, seg_pattern(seg_model[3:0]));
    check_seg("dpy1_o", dpy1, seg_pattern(seg_model[7:4]));
  endtask

  // Results are compared in completion order
  initial begin : compare_proc
    txn_t t;
    forever begin
      @(txn_ev);
      while (txn_q.size() != 0) begin
        t = txn_q.pop_front();
        check_resp(t.is_read ? "r_resp" : "b_resp", t.resp, ref_resp(t.addr));
        if (t.is_read) begin
          check_data($sformatf("r_data @ %h", t.addr), t.data, ref_read(t.addr));
        end else begin
          apply_write(t);
        end
        check_displays();
      end
    end
  end

  // ------------------------------
  // Bus tasks
  // ------------------------------
  task automatic post_result(input txn_t t);
    txn_q.push_back(t);
    -> txn_ev;
  endtask

  // Ready is sampled mid-cycle and the transfer is taken on the next rising edge
  task automatic wait_accept(input bit rd);
    bit taken;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = rd ? m_rsp.ar_ready : (m_rsp.aw_ready & m_rsp.w_ready);
      @(posedge clk);
      #2;
    end
  endtask

  // Ready stays low for the stall cycles while the payload has to hold
  task automatic wait_response(input bit rd, input int stall,
                               output soc_pkg::resp_e resp, output soc_pkg::data_t data);
    bit             seen;
    bit             done;
    bit             cur_valid;
    int             held;
    soc_pkg::resp_e cur_resp;
    soc_pkg::data_t cur_data;
    seen = 1'b0;
    done = 1'b0;
    held = 0;
    while (!done) begin
      @(negedge clk);
      cur_valid = rd ? m_rsp.r_valid : m_rsp.b_valid;
      cur_resp  = rd ? m_rsp.r_resp : m_rsp.b_resp;
      cur_data  = rd ? m_rsp.r_data : '0;
      if (cur_valid) begin
        if (!seen) begin
          resp = cur_resp;
          data = cur_data;
        end else if (resp !== cur_resp || data !== cur_data) begin
          $display("Response payload changed before the handshake completed");
          stop_on_error();
        end
        seen = 1'b1;
        held++;
        done = rd ? m_req.r_ready : m_req.b_ready;
      end else if (seen) begin
        $display("Response valid dropped before the handshake completed");
        stop_on_error();
      end
      @(posedge clk);
      #2;
      if (!done && rd) m_req.r_ready = (held >= stall);
      if (!done && !rd) m_req.b_ready = (held >= stall);
    end
    if (rd) m_req.r_ready = 1'b0;
    else m_req.b_ready = 1'b0;
  endtask

  task automatic bus_write(input soc_pkg::addr_t addr, input soc_pkg::data_t data,
                           input soc_pkg::strb_t strb, input int stall);
    soc_pkg::resp_e resp;
    soc_pkg::data_t no_data;
    m_req.aw_addr  = addr;
    m_req.w_data   = data;
    m_req.w_strb   = strb;
    m_req.aw_valid = 1'b1;
    m_req.w_valid  = 1'b1;
    m_req.b_ready  = (stall == 0);
    wait_accept(1'b0);
    m_req.aw_valid = 1'b0;
    m_req.w_valid  = 1'b0;
    wait_response(1'b0, stall, resp, no_data);
    post_result(txn_t'{1'b0, addr, data, strb, resp});
  endtask

  task automatic bus_read(input soc_pkg::addr_t addr, input int stall);
    soc_pkg::resp_e resp;
    soc_pkg::data_t data;
    m_req.ar_addr  = addr;
    m_req.ar_valid = 1'b1;
    m_req.r_ready  = (stall == 0);
    wait_accept(1'b1);
    m_req.ar_valid = 1'b0;
    wait_response(1'b1, stall, resp, data);
    post_result(txn_t'{1'b1, addr, data, 4'h0, resp});
  endtask

  function automatic soc_pkg::addr_t sram_addr(input int i);
    return {soc_pkg::SRAM_REGION, 16'h0, 10'(i * 61), 2'b00};
  endfunction

  function automatic soc_pkg::addr_t conf_addr(input logic [7:0] ofs);
    return {soc_pkg::CONF_REGION, 20'h0, ofs};
  endfunction

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial begin : stimulus
    soc_pkg::addr_t addr;
    soc_pkg::data_t wdata;
    soc_pkg::strb_t wstrb;
    int             k;
    int             wstall;
    int             rstall;
    void'($urandom(32'h8576));
    clk       = 1'b0;
    rst_n     = 1'b1;
    m_req     = '0;
    dip_sw    = '0;
    touch_btn = '0;
    led_model = '0;
    seg_model = '0;
    #2;
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;
    // Displays straight out of reset
    check_displays();

    // SRAM fill and strobe merges, then read back every word
    for (int i = 0; i < N_WORDS; i++) bus_write(sram_addr(i), $urandom(), 4'hF, 0);
    for (int i = 0; i < N_MERGE; i++) begin
      bus_write(sram_addr($urandom_range(0, N_WORDS - 1)), $urandom(),
                4'($urandom_range(1, 15)), 0);
    end
    for (int i = 0; i < N_WORDS; i++) bus_read(sram_addr(i), 0);

    // LED and SEG registers with byte strobes
    for (int i = 0; i < 4; i++) begin
      wstrb = (i == 0) ? 4'hF : 4'($urandom_range(1, 15));
      bus_write(conf_addr(soc_pkg::CR_LED_OFS), $urandom(), wstrb, 0);
      bus_write(conf_addr(soc_pkg::CR_SEG_OFS), $urandom(), wstrb, 0);
      bus_read(conf_addr(soc_pkg::CR_LED_OFS), 0);
      bus_read(conf_addr(soc_pkg::CR_SEG_OFS), 0);
    end

    // Switches, buttons and an unused offset
    for (int i = 0; i < 3; i++) begin
      // Previous button read is compared before the inputs move
      @(posedge clk);
      #2;
      dip_sw    = $urandom();
      touch_btn = 4'($urandom());
      bus_read(conf_addr(soc_pkg::CR_SW_OFS), 0);
      bus_read(conf_addr(soc_pkg::CR_BTN_OFS), 0);
    end
    bus_read(conf_addr(8'h10), 0);
    bus_read(conf_addr(8'hF0), 0);

    // Unmapped space with low bits shared with SRAM words
    for (int i = 0; i < 4; i++) begin
      addr = sram_addr(i);
      addr[31:28] = 4'($urandom_range(0, 15));
      if (addr[31:28] == soc_pkg::SRAM_REGION || addr[31:28] == soc_pkg::CONF_REGION) begin
        addr[31:28] ^= 4'h4;
      end
      bus_write(addr, $urandom(), 4'hF, 0);
      bus_read(addr, 0);
    end
    bus_read(sram_addr(0), 0);
    bus_read(sram_addr(1), 0);
    bus_read(conf_addr(soc_pkg::CR_LED_OFS), 0);
    bus_read(conf_addr(soc_pkg::CR_SEG_OFS), 0);

    // Overlapped write and read under random ready stalls
    for (int i = 0; i < N_OVERLAP; i++) begin
      k      = $urandom_range(0, N_WORDS - 1);
      wdata  = $urandom();
      wstrb  = 4'($urandom_range(1, 15));
      wstall = $urandom_range(0, MAX_STALL);
      rstall = $urandom_range(0, MAX_STALL);
      fork
        bus_write(sram_addr(k), wdata, wstrb, wstall);
        bus_read(sram_addr((k + 1) % N_WORDS), rstall);
      join
    end

    repeat (2) @(posedge clk);
    $display("All tests passed!");
    $finish;
  end

  initial begin : watchdog
    #((N_OPS * (MAX_STALL + 6) + RST_CYCLES) * CLK_PERIOD);
    $display("Bus hung: the watchdog expired before all transfers completed");
    stop_on_error();
  end

endmodule
